//--- Makefile
# Verilator build and run of the distribution tree testbench

VERILATOR ?= verilator
TOP       ?= tb_dist_tree4
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

# build, run, and pass only when the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- src/dist_pkg.sv
`default_nettype none

package dist_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// word width carried through the tree
	localparam int DATA_W = 32;

	// number of output lanes
	// one destination mask bit per lane
	localparam int NUM_LANES = 4;

	// switch command width
	// one bit per branch, same width as a branch valid pair
	localparam int CMD_W = 2;

	//////////////////////////////
	// types
	//////////////////////////////

	// one data word
	typedef logic [DATA_W-1:0] data_t;

	// destination mask, bit n selects lane n
	typedef logic [NUM_LANES-1:0] dest_t;

	// switch command
	// bit 0 drives the low branch, bit 1 the high branch
	typedef logic [CMD_W-1:0] sw_cmd_t;

	// valid pair of one switch
	// bit 0 low branch, bit 1 high branch
	typedef logic [CMD_W-1:0] lane_vld_t;

	//////////////////////////////
	// command codes
	//////////////////////////////

	// no branch, word dropped
	localparam sw_cmd_t CMD_NONE = 2'b00;

	// low branch only
	localparam sw_cmd_t CMD_LOW = 2'b01;

	// high branch only
	localparam sw_cmd_t CMD_HIGH = 2'b10;

	// both branches, word duplicated
	localparam sw_cmd_t CMD_BOTH = 2'b11;

endpackage

`default_nettype wire

//--- src/dist_route_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// routing control for the four-lane tree
// root command straight from the mask, leaf commands one stage later
module dist_route_ctrl
(
	// clock and sync reset
	input  wire                  clk,
	input  wire                  rst,

	// global enable, shared with the switches
	input  wire                  i_en,

	// incoming item
	input  wire                  i_valid,
	input  wire dist_pkg::dest_t i_dest,

	// root command, same cycle as the input
	output dist_pkg::sw_cmd_t o_root_cmd,

	// leaf commands, aligned with the root switch outputs
	output dist_pkg::sw_cmd_t o_leaf_lo_cmd,
	output dist_pkg::sw_cmd_t o_leaf_hi_cmd
);

	//////////////////////////////
	// root stage
	//////////////////////////////

	// any lane in 1:0 needs the low subtree
	logic need_lo;
	// any lane in 3:2 needs the high subtree
	logic need_hi;

	assign need_lo = |i_dest[1:0];
	assign need_hi = |i_dest[3:2];

	// validity is checked in the switch itself
	assign o_root_cmd = {need_hi, need_lo};

	//////////////////////////////
	// leaf stage
	//////////////////////////////

	// leaf command for lanes 1:0
	dist_pkg::sw_cmd_t leaf_lo_q;
	// leaf command for lanes 3:2
	dist_pkg::sw_cmd_t leaf_hi_q;

	// mask halves map straight onto leaf commands
	// lane bit 0 of a pair is the low branch, bit 1 the high branch
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			leaf_lo_q <= dist_pkg::CMD_NONE;
			leaf_hi_q <= dist_pkg::CMD_NONE;
		end
		else if (i_en)
		begin
			if (i_valid)
			begin
				leaf_lo_q <= i_dest[1:0];
				leaf_hi_q <= i_dest[3:2];
			end
			else
			begin
				// bubble, nothing to route next stage
				leaf_lo_q <= dist_pkg::CMD_NONE;
				leaf_hi_q <= dist_pkg::CMD_NONE;
			end
		end
	end

	// leaf commands leave with the root stage word
	assign o_leaf_lo_cmd = leaf_lo_q;
	assign o_leaf_hi_cmd = leaf_hi_q;

endmodule

`default_nettype wire

//--- src/dist_switch.sv
`timescale 1ns/1ps
`default_nettype none

// registered two-way distribute switch
// one word in, up to two copies out, one enabled edge later
module dist_switch
(
	// clock and sync reset
	input  wire                 i_clk,
	input  wire                 rst,

	// global enable, low freezes every register
	input  wire                 i_en,

	// incoming word
	input  wire                 i_valid,
	input  wire dist_pkg::data_t   i_data,

	// branch select for this word
	input  wire dist_pkg::sw_cmd_t i_cmd,

	// branch outputs
	output dist_pkg::lane_vld_t o_valid,
	output dist_pkg::data_t     o_data_lo,
	output dist_pkg::data_t     o_data_hi
);

	//////////////////////////////
	// next branch values
	//////////////////////////////

	// decoded branch valids
	dist_pkg::lane_vld_t vld_nxt;
	// low branch word, zero when not selected
	dist_pkg::data_t     lo_nxt;
	// high branch word, zero when not selected
	dist_pkg::data_t     hi_nxt;

	always_comb
	begin
		// dummy data by default
		vld_nxt = 2'b00;
		lo_nxt = '0;
		hi_nxt = '0;

		// only a valid word is routed
		if (i_valid)
		begin
			case (i_cmd)
				dist_pkg::CMD_LOW:
				begin
					vld_nxt = 2'b01;
					lo_nxt = i_data;
				end
				dist_pkg::CMD_HIGH:
				begin
					vld_nxt = 2'b10;
					hi_nxt = i_data;
				end
				dist_pkg::CMD_BOTH:
				begin
					// duplicate onto both branches
					vld_nxt = 2'b11;
					lo_nxt = i_data;
					hi_nxt = i_data;
				end
				default:
				begin
					// CMD_NONE, word is dropped
					vld_nxt = 2'b00;
					lo_nxt = '0;
					hi_nxt = '0;
				end
			endcase
		end
	end

	//////////////////////////////
	// output registers
	//////////////////////////////

	// reset wins over the enable
	// disabled edge holds everything so a tree stalls in step
	always_ff @(posedge i_clk)
	begin
		if (rst)
		begin
			o_valid <= 2'b00;
			o_data_lo <= '0;
			o_data_hi <= '0;
		end
		else if (i_en)
		begin
			o_valid <= vld_nxt;
			o_data_lo <= lo_nxt;
			o_data_hi <= hi_nxt;
		end
	end

endmodule

`default_nettype wire

//--- src/dist_tree4.sv
`timescale 1ns/1ps
`default_nettype none

// one-to-four distribution tree
// root switch splits into two leaf switches, two lanes each
// latency is two enabled edges, one item per stage in flight
module dist_tree4
(
	// clock and sync reset
	input  wire                  clk,
	input  wire                  rst,

	// global enable, low stalls the whole pipeline
	input  wire                  i_en,

	// source side
	input  wire                  i_valid,
	input  wire dist_pkg::dest_t i_dest,
	input  wire dist_pkg::data_t i_data,

	// lane side
	// o_valid bit n and o_data[n] belong to lane n
	output dist_pkg::dest_t                          o_valid,
	output dist_pkg::data_t [dist_pkg::NUM_LANES-1:0] o_data
);

	//////////////////////////////
	// routing commands
	//////////////////////////////

	// root command, combinational from the mask
	dist_pkg::sw_cmd_t root_cmd;
	// lane 1:0 command, registered
	dist_pkg::sw_cmd_t leaf_lo_cmd;
	// lane 3:2 command, registered
	dist_pkg::sw_cmd_t leaf_hi_cmd;

	dist_route_ctrl i_route
	(
		.clk           (clk),
		.rst           (rst),
		.i_en          (i_en),
		.i_valid       (i_valid),
		.i_dest        (i_dest),
		.o_root_cmd    (root_cmd),
		.o_leaf_lo_cmd (leaf_lo_cmd),
		.o_leaf_hi_cmd (leaf_hi_cmd)
	);

	//////////////////////////////
	// root stage
	//////////////////////////////

	// root branch valids
	// bit 0 feeds the low leaf, bit 1 the high leaf
	dist_pkg::lane_vld_t root_vld;
	// word toward lanes 1:0
	dist_pkg::data_t     root_data_lo;
	// word toward lanes 3:2
	dist_pkg::data_t     root_data_hi;

	dist_switch i_root_sw
	(
		.i_clk     (clk),
		.rst       (rst),
		.i_en      (i_en),
		.i_valid   (i_valid),
		.i_data    (i_data),
		.i_cmd     (root_cmd),
		.o_valid   (root_vld),
		.o_data_lo (root_data_lo),
		.o_data_hi (root_data_hi)
	);

	//////////////////////////////
	// leaf stage
	//////////////////////////////

	// low leaf outputs, lanes 1:0
	dist_pkg::lane_vld_t leaf_lo_vld;
	dist_pkg::data_t     lane0_data;
	dist_pkg::data_t     lane1_data;

	// high leaf outputs, lanes 3:2
	dist_pkg::lane_vld_t leaf_hi_vld;
	dist_pkg::data_t     lane2_data;
	dist_pkg::data_t     lane3_data;

	// leaf for lanes 1:0, fed from the root low branch
	dist_switch i_leaf_lo_sw
	(
		.i_clk     (clk),
		.rst       (rst),
		.i_en      (i_en),
		.i_valid   (root_vld[0]),
		.i_data    (root_data_lo),
		.i_cmd     (leaf_lo_cmd),
		.o_valid   (leaf_lo_vld),
		.o_data_lo (lane0_data),
		.o_data_hi (lane1_data)
	);

	// leaf for lanes 3:2, fed from the root high branch
	dist_switch i_leaf_hi_sw
	(
		.i_clk     (clk),
		.rst       (rst),
		.i_en      (i_en),
		.i_valid   (root_vld[1]),
		.i_data    (root_data_hi),
		.i_cmd     (leaf_hi_cmd),
		.o_valid   (leaf_hi_vld),
		.o_data_lo (lane2_data),
		.o_data_hi (lane3_data)
	);

	//////////////////////////////
	// lane packing
	//////////////////////////////

	// low leaf takes the low half of the mask
	assign o_valid = {leaf_hi_vld, leaf_lo_vld};

	// lane 0 lowest
	assign o_data[0] = lane0_data;
	assign o_data[1] = lane1_data;
	assign o_data[2] = lane2_data;
	assign o_data[3] = lane3_data;

endmodule

`default_nettype wire

//--- verif/dist_patterns.txt
// one item per line, all values in hex
// test number, mask, data word, expected lane mask, lane 0 to lane 3 words

// unicast to single lanes
2 1 11110001 1 11110001 00000000 00000000 00000000
2 2 11110002 2 00000000 11110002 00000000 00000000
2 4 11110003 4 00000000 00000000 11110003 00000000
2 8 11110004 8 00000000 00000000 00000000 11110004
2 8 2222a005 8 00000000 00000000 00000000 2222a005
2 4 2222a006 4 00000000 00000000 2222a006 00000000
2 2 2222a007 2 00000000 2222a007 00000000 00000000
2 1 2222a008 1 2222a008 00000000 00000000 00000000

// multicast and broadcast masks
3 3 33330003 3 33330003 33330003 00000000 00000000
3 5 33330005 5 33330005 00000000 33330005 00000000
3 6 33330006 6 00000000 33330006 33330006 00000000
3 9 33330009 9 33330009 00000000 00000000 33330009
3 a 3333000a a 00000000 3333000a 00000000 3333000a
3 c 3333000c c 00000000 00000000 3333000c 3333000c
3 7 33330007 7 33330007 33330007 33330007 00000000
3 b 3333000b b 3333000b 3333000b 00000000 3333000b
3 d 3333000d d 3333000d 00000000 3333000d 3333000d
3 e 3333000e e 00000000 3333000e 3333000e 3333000e
3 f 3333000f f 3333000f 3333000f 3333000f 3333000f

// dropped items with empty masks
4 1 44440001 1 44440001 00000000 00000000 00000000
4 0 44440002 0 00000000 00000000 00000000 00000000
4 0 44440003 0 00000000 00000000 00000000 00000000
4 c 44440004 c 00000000 00000000 44440004 44440004
4 0 44440005 0 00000000 00000000 00000000 00000000
4 6 44440006 6 00000000 44440006 44440006 00000000
4 0 44440007 0 00000000 00000000 00000000 00000000
4 f 44440008 f 44440008 44440008 44440008 44440008

// random stall
5 1 55550001 1 55550001 00000000 00000000 00000000
5 f 55550002 f 55550002 55550002 55550002 55550002
5 2 55550003 2 00000000 55550003 00000000 00000000
5 0 55550004 0 00000000 00000000 00000000 00000000
5 a 55550005 a 00000000 55550005 00000000 55550005
5 4 55550006 4 00000000 00000000 55550006 00000000
5 3 55550007 3 55550007 55550007 00000000 00000000
5 8 55550008 8 00000000 00000000 00000000 55550008
5 5 55550009 5 55550009 00000000 55550009 00000000
5 e 5555000a e 00000000 5555000a 5555000a 5555000a
5 c 5555000b c 00000000 00000000 5555000b 5555000b
5 9 5555000c 9 5555000c 00000000 00000000 5555000c
5 7 5555000d 7 5555000d 5555000d 5555000d 00000000
5 b 5555000e b 5555000e 5555000e 00000000 5555000e

// back to back at full rate
6 1 66660001 1 66660001 00000000 00000000 00000000
6 2 66660002 2 00000000 66660002 00000000 00000000
6 4 66660003 4 00000000 00000000 66660003 00000000
6 8 66660004 8 00000000 00000000 00000000 66660004
6 f 66660005 f 66660005 66660005 66660005 66660005
6 3 66660006 3 66660006 66660006 00000000 00000000
6 c 66660007 c 00000000 00000000 66660007 66660007
6 5 66660008 5 66660008 00000000 66660008 00000000
6 a 66660009 a 00000000 66660009 00000000 66660009
6 6 6666000a 6 00000000 6666000a 6666000a 00000000
6 9 6666000b 9 6666000b 00000000 00000000 6666000b
6 f 6666000c f 6666000c 6666000c 6666000c 6666000c

//--- verif/tb_dist_tree4.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dist_tree4;

	//////////////////////////////
	// constants
	//////////////////////////////

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 4;
	localparam int SEED = 12081;
	// words on one pattern line
	localparam int ITEM_W = 8;
	localparam int MAX_ITEMS = 64;
	localparam int PAT_WORDS = ITEM_W * MAX_ITEMS;
	// enabled edges from accept to sample
	localparam int LATENCY = 2;
	// idle cycles allowed for the pipeline to empty
	localparam int DRAIN_MAX = 10;
	localparam int CHK_W = dist_pkg::DATA_W * dist_pkg::NUM_LANES;
	localparam int TEST_DROP = 4;
	localparam int TEST_STALL = 5;

	// dut ports
	logic clk;
	logic rst;
	logic i_en;
	logic i_valid;
	dist_pkg::dest_t i_dest;
	dist_pkg::data_t i_data;
	dist_pkg::dest_t o_valid;
	dist_pkg::data_t [dist_pkg::NUM_LANES-1:0] o_data;

	// pattern memory, zero test number ends the list
	logic [31:0] pat_mem [0:PAT_WORDS-1];
	int num_items = 0;
	logic loaded = 1'b0;

	// expectation for the item now on the inputs
	dist_pkg::dest_t exp_vld;
	logic [CHK_W-1:0] exp_data;

	// scoreboard queues, one entry per routed item
	dist_pkg::dest_t exp_vld_q [$];
	logic [CHK_W-1:0] exp_data_q [$];
	int exp_edge_q [$];

	// monitor state
	int err_cnt = 0;
	int en_edges = 0;
	int cyc = 0;
	logic was_stalled = 1'b0;
	dist_pkg::dest_t held_valid;
	logic [CHK_W-1:0] held_data;
	dist_pkg::dest_t want_vld;
	logic [CHK_W-1:0] want_data;
	int want_edge;

	// test counts
	int pass_cnt;
	int fail_cnt;
	int reset_errs;

	dist_tree4 i_dist_tree4
	(
		.clk     (clk),
		.rst     (rst),
		.i_en    (i_en),
		.i_valid (i_valid),
		.i_dest  (i_dest),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

	// free running clock
	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task check_val(input string name, input logic [CHK_W-1:0] got, input logic [CHK_W-1:0] exp);
		begin
			if (got !== exp)
			begin
				$display("error: %s got %h expected %h", name, got, exp);
				err_cnt++;
			end
		end
	endtask

	task load_patterns();
		begin
			// clear first so the end of the list reads as zero
			for (int i = 0; i < PAT_WORDS; i++)
				pat_mem[i] = '0;
			$readmemh("verif/dist_patterns.txt", pat_mem);
			num_items = 0;
			while (num_items < MAX_ITEMS && pat_mem[num_items * ITEM_W] != 0)
				num_items++;
		end
	endtask

	// present one item, retrying over stalled cycles
	task drive_item(input int idx, input logic stall);
		int base;
		logic en_bit;
		begin
			base = idx * ITEM_W;
			en_bit = 1'b0;
			while (!en_bit)
			begin
				@(negedge clk);
				en_bit = stall ? ($urandom % 3 != 0) : 1'b1;
				i_en = en_bit;
				if (en_bit)
				begin
					i_valid = 1'b1;
					i_dest = dist_pkg::dest_t'(pat_mem[base + 1]);
					i_data = pat_mem[base + 2];
					exp_vld = dist_pkg::dest_t'(pat_mem[base + 3]);
					// lane 0 in the low word
					exp_data = {pat_mem[base + 7], pat_mem[base + 6],
						pat_mem[base + 5], pat_mem[base + 4]};
				end
				else
				begin
					// garbage while stalled, must be ignored
					i_valid = ($urandom % 2 == 1);
					i_dest = dist_pkg::dest_t'($urandom);
					i_data = $urandom;
				end
			end
		end
	endtask

	// bubble with a live-looking mask
	task drive_idle();
		begin
			@(negedge clk);
			i_en = 1'b1;
			i_valid = 1'b0;
			i_dest = dist_pkg::dest_t'($urandom);
			i_data = $urandom;
		end
	endtask

	task drain_pipeline(output int missing);
		int waited;
		begin
			@(negedge clk);
			i_en = 1'b1;
			i_valid = 1'b0;
			i_dest = '0;
			i_data = '0;
			waited = 0;
			while (exp_vld_q.size() != 0 && waited < DRAIN_MAX)
			begin
				@(negedge clk);
				waited++;
			end
			// let trailing empty-mask items flush through
			repeat (3) @(negedge clk);
			missing = exp_vld_q.size();
			if (missing != 0)
				$display("%0d expected items never reached the lanes", missing);
		end
	endtask

	task report_test(input int num, input string name, input int errs_before, input int missing);
		begin
			if (err_cnt == errs_before && missing == 0)
			begin
				pass_cnt++;
				$display("test %0d %s: passed", num, name);
			end
			else
			begin
				fail_cnt++;
				$display("test %0d %s: failed with %0d errors, %0d items missing",
					num, name, err_cnt - errs_before, missing);
			end
		end
	endtask

	// every pattern line of one test, then drain
	task run_test(input int num, input string name);
		int errs_before;
		int missing;
		begin
			errs_before = err_cnt;
			for (int i = 0; i < num_items; i++)
			begin
				if (pat_mem[i * ITEM_W] == num)
				begin
					drive_item(i, num == TEST_STALL);
					if (num == TEST_DROP)
						drive_idle();
				end
			end
			drain_pipeline(missing);
			report_test(num, name, errs_before, missing);
		end
	endtask

	//////////////////////////////
	// monitor and scoreboard
	//////////////////////////////

	// outputs only move on enabled edges, so each state is seen once here
	always @(posedge clk)
	begin
		if (rst)
		begin
			// cleared from the first reset edge on
			if (cyc > 0)
			begin
				check_val("o_valid", CHK_W'(o_valid), '0);
				check_val("o_data", o_data, '0);
			end
			was_stalled = 1'b0;
		end
		else
		begin
			// previous edge was disabled, nothing may move
			if (was_stalled)
			begin
				check_val("o_valid", CHK_W'(o_valid), CHK_W'(held_valid));
				check_val("o_data", o_data, held_data);
			end
			if (i_en)
			begin
				if (o_valid == '0)
				begin
					// idle lanes carry dummy zero data
					check_val("o_data", o_data, '0);
				end
				else if (exp_vld_q.size() == 0)
				begin
					$display("lanes %b went valid with no item expected", o_valid);
					err_cnt++;
				end
				else
				begin
					want_vld = exp_vld_q.pop_front();
					want_data = exp_data_q.pop_front();
					want_edge = exp_edge_q.pop_front();
					check_val("o_valid", CHK_W'(o_valid), CHK_W'(want_vld));
					check_val("o_data", o_data, want_data);
					if (en_edges - want_edge != LATENCY)
					begin
						$display("item arrived %0d enabled edges after its input instead of %0d",
							en_edges - want_edge, LATENCY);
						err_cnt++;
					end
				end
				// accepted item with somewhere to go
				if (i_valid && exp_vld != '0)
				begin
					exp_vld_q.push_back(exp_vld);
					exp_data_q.push_back(exp_data);
					exp_edge_q.push_back(en_edges);
				end
				en_edges++;
			end
			held_valid = o_valid;
			held_data = o_data;
			was_stalled = !i_en;
		end
		cyc++;
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial
	begin
		void'($urandom(SEED));
		rst = 1'b1;
		i_en = 1'b1;
		i_valid = 1'b0;
		i_dest = '0;
		i_data = '0;
		exp_vld = '0;
		exp_data = '0;
		pass_cnt = 0;
		fail_cnt = 0;
		load_patterns();
		if (num_items == 0)
		begin
			$display("no items could be read from verif/dist_patterns.txt");
			fail_cnt++;
		end
		loaded = 1'b1;

		// reset with enable high and no input
		reset_errs = err_cnt;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);
		report_test(1, "reset", reset_errs, 0);

		run_test(2, "unicast");
		run_test(3, "multicast");
		run_test(TEST_DROP, "drop");
		run_test(TEST_STALL, "stall");
		run_test(6, "throughput");

		$display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// budget of four cycles per item plus slack
	initial
	begin
		wait (loaded);
		#((num_items + 20) * 4 * CLK_PERIOD);
		$display("watchdog expired before the tests could finish");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
src/dist_pkg.sv
src/dist_switch.sv
src/dist_route_ctrl.sv
src/dist_tree4.sv
verif/tb_dist_tree4.sv
